// File: verilog/motor_pkg.sv
package motor_pkg;

	// axis state, top bit set means the axis is busy
	typedef enum logic [1:0] {
		IDLE    = 2'b00,
		PREPARE = 2'b10,
		RUNNING = 2'b11
	} motor_state_e;

	// default widths
	localparam int step_width_default  = 16;
	localparam int speed_width_default = 16;
	localparam int addr_width_default  = 9;
	localparam int ms_width_default    = 3;

	// ramp rule: slowest period at entry 0, linear speed-up per entry
	localparam logic [15:0] ramp_start = 16'd12;
	localparam logic [15:0] ramp_slope = 16'd2;

	// period of ramp table entry n, clamped at one tick
	function automatic logic [15:0] ramp_entry(input int unsigned n);
		int unsigned drop;
		drop = n * ramp_slope;
		if (drop >= ramp_start) begin
			return 16'd1;
		end
		return ramp_start - drop[15:0];
	endfunction

endpackage

// File: verilog/ramp_table.sv
`timescale 1ns/10ps

module ramp_table #(
	parameter int addr_width  = motor_pkg::addr_width_default,
	parameter int speed_width = motor_pkg::speed_width_default
) (
	input  logic                   clk,
	input  logic                   i_en,
	input  logic [addr_width-1:0]  i_addr,
	output logic [speed_width-1:0] o_data
);

	localparam int depth = 2 ** addr_width;

	logic [speed_width-1:0] rom [depth];
	logic [speed_width-1:0] rd_q;

	initial begin
		for (int n = 0; n < depth; n++) begin
			rom[n] = speed_width'(motor_pkg::ramp_entry(n));
		end
	end

	// two read stages, like a block RAM with output register
	always_ff @(posedge clk) begin
		if (i_en) begin
			rd_q <= rom[i_addr];
		end
		o_data <= rd_q;
	end

endmodule

// File: verilog/speed_profile.sv
`timescale 1ns/10ps

module speed_profile #(
	parameter int step_width  = motor_pkg::step_width_default,
	parameter int speed_width = motor_pkg::speed_width_default,
	parameter int addr_width  = motor_pkg::addr_width_default
) (
	input  logic                   clk,
	input  logic                   i_req,
	input  logic [step_width-1:0]  i_step_cnt,
	input  logic [step_width-1:0]  i_step_remain,
	input  logic [addr_width-1:0]  i_acce_max,
	input  logic [addr_width-1:0]  i_deac_max,
	input  logic [speed_width-1:0] i_speed_max,
	output logic [speed_width-1:0] o_speed_cur
);

	// request delayed by one to five clocks
	logic [4:0]             req_pipe;
	logic                   acce_ing;
	logic                   deac_ing;
	logic [addr_width-1:0]  acce_addr;
	logic [addr_width-1:0]  deac_addr;
	logic [speed_width-1:0] acce_data;
	logic [speed_width-1:0] deac_data;
	logic [speed_width-1:0] speed_var;

	always_ff @(posedge clk) begin
		req_pipe <= {req_pipe[3:0], i_req};
	end

	// still on the ramp?
	always_ff @(posedge clk) begin
		if (i_req) begin
			acce_ing <= (i_step_cnt < step_width'(i_acce_max));
			deac_ing <= (i_step_remain < step_width'(i_deac_max));
		end
	end

	// past the limit the table holds at its last entry
	always_ff @(posedge clk) begin
		if (req_pipe[0]) begin
			acce_addr <= acce_ing ? i_step_cnt[addr_width-1:0] : i_acce_max;
			deac_addr <= deac_ing ? i_step_remain[addr_width-1:0] : i_deac_max;
		end
	end

	ramp_table #(
		.addr_width  (addr_width),
		.speed_width (speed_width)
	) u_acce_table (
		.clk    (clk),
		.i_en   (req_pipe[1]),
		.i_addr (acce_addr),
		.o_data (acce_data)
	);

	ramp_table #(
		.addr_width  (addr_width),
		.speed_width (speed_width)
	) u_deac_table (
		.clk    (clk),
		.i_en   (req_pipe[1]),
		.i_addr (deac_addr),
		.o_data (deac_data)
	);

	// larger period is the slower step, so the maximum wins
	always_ff @(posedge clk) begin
		if (req_pipe[3]) begin
			speed_var <= (acce_data > deac_data) ? acce_data : deac_data;
		end
	end

	always_ff @(posedge clk) begin
		if (req_pipe[4]) begin
			o_speed_cur <= (speed_var > i_speed_max) ? speed_var : i_speed_max;
		end
	end

endmodule

// File: verilog/step_pulse_gen.sv
`timescale 1ns/10ps

module step_pulse_gen #(
	parameter int step_width  = motor_pkg::step_width_default,
	parameter int speed_width = motor_pkg::speed_width_default
) (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    i_tick,
	input  motor_pkg::motor_state_e i_state,
	input  logic                    i_load,
	input  logic [step_width-1:0]   i_steps,
	input  logic [speed_width-1:0]  i_speed_cur,
	output logic                    o_drive,
	output logic                    o_rd_req,
	output logic [step_width-1:0]   o_step_cnt,
	output logic [step_width-1:0]   o_step_remain,
	output logic                    o_done_end
);

	logic [speed_width-1:0] speed_cnt;
	logic                   step_done;
	logic                   cnt_zero;
	logic                   step_end;
	logic                   running;

	assign running  = (i_state == motor_pkg::RUNNING);
	assign cnt_zero = (speed_cnt == '0);
	// drive falls here, so a full step is complete
	assign step_end = cnt_zero && o_drive;
	assign o_done_end = step_done && cnt_zero;

	// lookup for the next step, one clock wide
	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_rd_req <= 1'b0;
		end else if (o_rd_req) begin
			o_rd_req <= 1'b0;
		end else if (i_tick) begin
			o_rd_req <= running && step_end;
		end
	end

	// period counter, holds through PREPARE
	always_ff @(posedge clk) begin
		if (!resetn) begin
			speed_cnt <= '0;
		end else if (i_tick) begin
			if (i_state == motor_pkg::IDLE) begin
				speed_cnt <= '0;
			end else if (running) begin
				speed_cnt <= cnt_zero ? i_speed_cur : speed_cnt - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_drive <= 1'b0;
		end else if (i_tick) begin
			if (!running) begin
				o_drive <= 1'b0;
			end else if (cnt_zero && !step_done) begin
				o_drive <= !o_drive;
			end
		end
	end

	// set on the last step, kept through the final half step
	always_ff @(posedge clk) begin
		if (!resetn) begin
			step_done <= 1'b0;
		end else if (i_tick) begin
			if (!running) begin
				step_done <= 1'b0;
			end else if (step_end && o_step_remain == '0) begin
				step_done <= 1'b1;
			end
		end
	end

	// step counters also address the ramp tables
	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_step_cnt    <= '0;
			o_step_remain <= '0;
		end else if (i_load) begin
			o_step_cnt    <= '0;
			o_step_remain <= i_steps - 1'b1;
		end else if (i_tick && running && step_end) begin
			o_step_cnt    <= o_step_cnt + 1'b1;
			o_step_remain <= o_step_remain - 1'b1;
		end
	end

endmodule

// File: verilog/position_tracker.sv
`timescale 1ns/10ps

module position_tracker #(
	parameter int step_width = motor_pkg::step_width_default
) (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic                  i_drive,
	input  logic                  i_dir,
	input  logic                  i_zpd,
	input  logic [step_width-1:0] i_stroke,
	input  logic                  i_done_end,
	output logic                  o_zpsign,
	output logic                  o_tpsign,
	output logic                  o_end_req
);

	localparam logic [step_width-1:0] init_pos = step_width'(1);

	logic                  drive_d1;
	logic                  drive_fall;
	logic                  forward;
	logic                  at_stroke;
	logic [step_width-1:0] position;

	// dir 0 moves away from the zero switch
	assign forward    = !i_dir;
	assign drive_fall = drive_d1 && !i_drive;
	assign at_stroke  = (position == i_stroke);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			drive_d1 <= 1'b0;
		end else begin
			drive_d1 <= i_drive;
		end
	end

	// zero switch reloads the home position
	always_ff @(posedge clk) begin
		if (!resetn || i_zpd) begin
			position <= init_pos;
		end else if (drive_fall) begin
			if (forward && !at_stroke) begin
				position <= position + 1'b1;
			end else if (!forward && position > init_pos) begin
				position <= position - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_tpsign <= 1'b0;
		end else if (drive_fall) begin
			o_tpsign <= at_stroke;
		end
	end

	assign o_zpsign  = i_zpd;
	assign o_end_req = i_done_end || (o_tpsign && forward) || (i_zpd && !forward);

endmodule

// File: verilog/motor_ctrl.sv
`timescale 1ns/10ps

module motor_ctrl #(
	parameter int speed_width   = motor_pkg::speed_width_default,
	parameter int ms_width      = motor_pkg::ms_width_default,
	parameter int reverse_delay = 4
) (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    i_tick,
	input  logic                    i_start,
	input  logic                    i_stop,
	input  logic                    i_dir,
	input  logic [speed_width-1:0]  i_speed,
	input  logic [ms_width-1:0]     i_ms,
	input  logic                    i_end_req,
	output motor_pkg::motor_state_e o_state,
	output logic                    o_load,
	output logic                    o_start_req,
	output logic                    o_dir,
	output logic [speed_width-1:0]  o_speed_max,
	output logic [ms_width-1:0]     o_ms
);

	// counter only has to reach reverse_delay - 2
	localparam int dly_width = (reverse_delay > 2) ? $clog2(reverse_delay) : 1;
	localparam logic [dly_width-1:0] dly_last = dly_width'(reverse_delay - 2);

	motor_pkg::motor_state_e state;
	logic                    is_idle;
	logic                    start_d1;
	logic                    stop_d1;
	logic                    start_pend;
	logic                    stop_pend;
	logic                    should_start;
	logic [dly_width-1:0]    dly_cnt;

	assign is_idle = (state == motor_pkg::IDLE);
	assign o_state = state;

	// input history for edge detection
	always_ff @(posedge clk) begin
		if (!resetn) begin
			start_d1 <= 1'b0;
			stop_d1  <= 1'b0;
		end else begin
			start_d1 <= i_start;
			stop_d1  <= i_stop;
		end
	end

	// start edge held until the next tick
	always_ff @(posedge clk) begin
		if (!resetn) begin
			start_pend <= 1'b0;
		end else if (start_pend) begin
			if (i_tick) begin
				start_pend <= 1'b0;
			end
		end else if (i_start && !start_d1 && is_idle) begin
			start_pend <= 1'b1;
		end
	end

	// stop edge, only seen while busy
	always_ff @(posedge clk) begin
		if (!resetn) begin
			stop_pend <= 1'b0;
		end else if (stop_pend) begin
			if (i_tick) begin
				stop_pend <= 1'b0;
			end
		end else if (i_stop && !stop_d1 && !is_idle) begin
			stop_pend <= 1'b1;
		end
	end

	assign should_start = i_tick && start_pend && is_idle;
	assign o_load = should_start;

	// first speed lookup of a move
	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_start_req <= 1'b0;
		end else begin
			o_start_req <= should_start;
		end
	end

	// command latch
	always_ff @(posedge clk) begin
		if (should_start) begin
			o_speed_max <= i_speed;
			o_ms        <= i_ms;
		end
	end

	// direction is compared against the next command, so it starts known
	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_dir <= 1'b0;
		end else if (should_start) begin
			o_dir <= i_dir;
		end
	end

	// reverse delay, counts PREPARE ticks
	always_ff @(posedge clk) begin
		if (!resetn) begin
			dly_cnt <= '0;
		end else if (i_tick) begin
			if (state == motor_pkg::PREPARE) begin
				dly_cnt <= dly_cnt + 1'b1;
			end else begin
				dly_cnt <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= motor_pkg::IDLE;
		end else if (i_tick) begin
			case (state)
				motor_pkg::IDLE: begin
					if (start_pend) begin
						state <= (o_dir == i_dir) ? motor_pkg::RUNNING : motor_pkg::PREPARE;
					end
				end
				motor_pkg::PREPARE: begin
					if (stop_pend) begin
						state <= motor_pkg::IDLE;
					end else if (dly_cnt == dly_last) begin
						state <= motor_pkg::RUNNING;
					end
				end
				motor_pkg::RUNNING: begin
					// stop strobe, last half step or end of travel
					if (stop_pend || i_end_req) begin
						state <= motor_pkg::IDLE;
					end
				end
				default: state <= motor_pkg::IDLE;
			endcase
		end
	end

endmodule

// File: verilog/stepper_axis.sv
`timescale 1ns/10ps

module stepper_axis #(
	parameter int step_width    = motor_pkg::step_width_default,
	parameter int speed_width   = motor_pkg::speed_width_default,
	parameter int addr_width    = motor_pkg::addr_width_default,
	parameter int ms_width      = motor_pkg::ms_width_default,
	parameter int reverse_delay = 4
) (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   i_tick,
	input  logic                   i_start,
	input  logic                   i_stop,
	input  logic                   i_dir,
	input  logic [speed_width-1:0] i_speed,
	input  logic [step_width-1:0]  i_step,
	input  logic [ms_width-1:0]    i_ms,
	input  logic [addr_width-1:0]  i_acce_max,
	input  logic [addr_width-1:0]  i_deac_max,
	input  logic                   i_zpd,
	input  logic [step_width-1:0]  i_stroke,
	input  logic                   i_xen,
	input  logic                   i_xrst,
	output logic                   o_drive,
	output logic                   o_dir,
	output logic [ms_width-1:0]    o_ms,
	output logic                   o_state,
	output logic [speed_width-1:0] o_speed,
	output logic                   o_zpsign,
	output logic                   o_tpsign,
	output logic                   o_xen,
	output logic                   o_xrst
);

	motor_pkg::motor_state_e state;
	logic                    load;
	logic                    start_req;
	logic                    rd_req;
	logic                    done_end;
	logic                    end_req;
	logic [speed_width-1:0]  speed_max;
	logic [step_width-1:0]   step_cnt;
	logic [step_width-1:0]   step_remain;

	assign o_state = (state != motor_pkg::IDLE);

	// driver enable and reset go straight through
	assign o_xen  = i_xen;
	assign o_xrst = i_xrst;

	motor_ctrl #(
		.speed_width   (speed_width),
		.ms_width      (ms_width),
		.reverse_delay (reverse_delay)
	) u_motor_ctrl (
		.clk         (clk),
		.resetn      (resetn),
		.i_tick      (i_tick),
		.i_start     (i_start),
		.i_stop      (i_stop),
		.i_dir       (i_dir),
		.i_speed     (i_speed),
		.i_ms        (i_ms),
		.i_end_req   (end_req),
		.o_state     (state),
		.o_load      (load),
		.o_start_req (start_req),
		.o_dir       (o_dir),
		.o_speed_max (speed_max),
		.o_ms        (o_ms)
	);

	// start lookup and per-step lookups share the pipeline
	speed_profile #(
		.step_width  (step_width),
		.speed_width (speed_width),
		.addr_width  (addr_width)
	) u_speed_profile (
		.clk           (clk),
		.i_req         (start_req || rd_req),
		.i_step_cnt    (step_cnt),
		.i_step_remain (step_remain),
		.i_acce_max    (i_acce_max),
		.i_deac_max    (i_deac_max),
		.i_speed_max   (speed_max),
		.o_speed_cur   (o_speed)
	);

	step_pulse_gen #(
		.step_width  (step_width),
		.speed_width (speed_width)
	) u_step_pulse_gen (
		.clk           (clk),
		.resetn        (resetn),
		.i_tick        (i_tick),
		.i_state       (state),
		.i_load        (load),
		.i_steps       (i_step),
		.i_speed_cur   (o_speed),
		.o_drive       (o_drive),
		.o_rd_req      (rd_req),
		.o_step_cnt    (step_cnt),
		.o_step_remain (step_remain),
		.o_done_end    (done_end)
	);

	position_tracker #(
		.step_width (step_width)
	) u_position_tracker (
		.clk        (clk),
		.resetn     (resetn),
		.i_drive    (o_drive),
		.i_dir      (o_dir),
		.i_zpd      (i_zpd),
		.i_stroke   (i_stroke),
		.i_done_end (done_end),
		.o_zpsign   (o_zpsign),
		.o_tpsign   (o_tpsign),
		.o_end_req  (end_req)
	);

endmodule

// File: testbench/stepper_axis_sva.sv
`timescale 1ns/10ps

module stepper_axis_sva (
	input logic clk,
	input logic resetn,
	input logic i_state,
	input logic i_drive,
	input logic i_dir,
	input logic i_xen,
	input logic i_xrst,
	input logic i_xen_out,
	input logic i_xrst_out
);

	// no step pulse outside a move
	drive_low_idle: assert property (@(posedge clk) disable iff (!resetn)
		!i_state |-> !i_drive)
		else $error("step output high while the axis is idle");

	// direction only changes on the edge that starts a move
	dir_stable_busy: assert property (@(posedge clk) disable iff (!resetn)
		i_state && $past(i_state) |-> $stable(i_dir))
		else $error("direction changed during a move");

	xen_passed: assert property (@(posedge clk) i_xen_out == i_xen)
		else $error("driver enable does not follow its input");

	xrst_passed: assert property (@(posedge clk) i_xrst_out == i_xrst)
		else $error("driver reset does not follow its input");

endmodule

bind stepper_axis stepper_axis_sva u_stepper_axis_sva (
	.clk        (clk),
	.resetn     (resetn),
	.i_state    (o_state),
	.i_drive    (o_drive),
	.i_dir      (o_dir),
	.i_xen      (i_xen),
	.i_xrst     (i_xrst),
	.i_xen_out  (o_xen),
	.i_xrst_out (o_xrst)
);

// File: testbench/tb_stepper_axis.sv
`timescale 1ns/10ps

module tb_stepper_axis;

	localparam int step_width    = motor_pkg::step_width_default;
	localparam int speed_width   = motor_pkg::speed_width_default;
	localparam int addr_width    = motor_pkg::addr_width_default;
	localparam int ms_width      = motor_pkg::ms_width_default;
	localparam int reverse_delay = 4;
	// one line of the pattern file per move
	localparam int n_pat   = 10;
	localparam int n_field = 11;

	logic                   clk;
	logic                   resetn;
	logic                   tick;
	logic                   start;
	logic                   stop;
	logic                   cmd_dir;
	logic [speed_width-1:0] cmd_speed;
	logic [step_width-1:0]  cmd_steps;
	logic [ms_width-1:0]    cmd_ms;
	logic [addr_width-1:0]  acce_max;
	logic [addr_width-1:0]  deac_max;
	logic                   zpd;
	logic [step_width-1:0]  stroke;
	logic                   xen;
	logic                   xrst;
	logic                   drive;
	logic                   axis_dir;
	logic [ms_width-1:0]    axis_ms;
	logic                   busy;
	logic [speed_width-1:0] speed_now;
	logic                   zpsign;
	logic                   tpsign;
	logic                   xen_out;
	logic                   xrst_out;

	logic [15:0] pat_mem [n_pat*n_field];
	int unsigned cycle_count;
	int unsigned cycle_limit;
	int unsigned tick_count;
	int unsigned start_tick;
	int unsigned rise_count;
	int unsigned fall_count;
	int unsigned first_rise_delay;
	int unsigned phase;
	logic        drive_prev;
	logic        last_dir;

	stepper_axis #(
		.step_width    (step_width),
		.speed_width   (speed_width),
		.addr_width    (addr_width),
		.ms_width      (ms_width),
		.reverse_delay (reverse_delay)
	) i_stepper_axis (
		.clk        (clk),
		.resetn     (resetn),
		.i_tick     (tick),
		.i_start    (start),
		.i_stop     (stop),
		.i_dir      (cmd_dir),
		.i_speed    (cmd_speed),
		.i_step     (cmd_steps),
		.i_ms       (cmd_ms),
		.i_acce_max (acce_max),
		.i_deac_max (deac_max),
		.i_zpd      (zpd),
		.i_stroke   (stroke),
		.i_xen      (xen),
		.i_xrst     (xrst),
		.o_drive    (drive),
		.o_dir      (axis_dir),
		.o_ms       (axis_ms),
		.o_state    (busy),
		.o_speed    (speed_now),
		.o_zpsign   (zpsign),
		.o_tpsign   (tpsign),
		.o_xen      (xen_out),
		.o_xrst     (xrst_out)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = !clk;
		end
	end

	task automatic abort_run();
		$display("Checks failed");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic report_mismatch(input string msg);
		$display("Fail at %0t ns: %s", $time, msg);
		abort_run();
	endtask

	// sample outputs at the falling edge and drive the next tick
	task automatic step_clock();
		int unsigned            since_start;
		logic [speed_width-1:0] speed_hi;
		@(negedge clk);
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("Timeout: the moves did not finish within %0d clock cycles", cycle_limit);
			abort_run();
		end
		if (tick) begin
			tick_count++;
		end
		since_start = tick_count - start_tick;
		if (drive && !drive_prev) begin
			rise_count++;
			if (rise_count == 1) begin
				first_rise_delay = since_start;
			end
		end
		if (!drive && drive_prev) begin
			fall_count++;
		end
		drive_prev = drive;
		assert (zpsign == zpd)
			else report_mismatch($sformatf("zpsign %0b, zero switch %0b", zpsign, zpd));
		assert (xen_out == xen && xrst_out == xrst)
			else report_mismatch($sformatf("driver enable %0b reset %0b, inputs %0b %0b",
				xen_out, xrst_out, xen, xrst));
		// period never exceeds the slower of ramp start and command
		speed_hi = (cmd_speed > motor_pkg::ramp_start) ? cmd_speed : motor_pkg::ramp_start;
		if (busy && since_start >= 2) begin
			assert (speed_now >= cmd_speed && speed_now <= speed_hi)
				else report_mismatch($sformatf("period %0d outside %0d..%0d",
					speed_now, cmd_speed, speed_hi));
		end
		phase = (phase + 1) % 8;
		tick = (phase == 7);
	endtask

	task automatic run_move(input int p);
		int          b;
		int unsigned stop_at;
		int unsigned zpd_at;
		int unsigned exp_delay;
		int unsigned gap;
		b = p * n_field;
		cmd_dir   = pat_mem[b][0];
		cmd_steps = pat_mem[b+1];
		cmd_speed = pat_mem[b+2];
		cmd_ms    = pat_mem[b+3][ms_width-1:0];
		acce_max  = pat_mem[b+4][addr_width-1:0];
		deac_max  = pat_mem[b+5][addr_width-1:0];
		stop_at   = 32'(pat_mem[b+6]);
		zpd_at    = 32'(pat_mem[b+7]);
		stroke    = pat_mem[b+8];
		xen       = p[1];
		xrst      = p[0];
		exp_delay = (cmd_dir == last_dir) ? 2 : 2 + reverse_delay - 1;
		// strobe right after a tick keeps the delay count exact
		while (phase != 0) begin
			step_clock();
		end
		rise_count       = 0;
		fall_count       = 0;
		first_rise_delay = 0;
		start_tick       = tick_count;
		start            = 1'b1;
		while (!busy) begin
			step_clock();
		end
		start = 1'b0;
		while (busy) begin
			step_clock();
			if (stop_at != 0 && fall_count == stop_at) begin
				stop = 1'b1;
			end
			if (zpd_at != 0 && fall_count == zpd_at) begin
				zpd = 1'b1;
			end
		end
		stop = 1'b0;
		zpd  = 1'b0;
		// quiet gap where a late pulse would still be counted
		gap = 16 + ($urandom % 16);
		repeat (gap) begin
			step_clock();
		end
		last_dir = cmd_dir;
		if (stop_at != 0) begin
			assert (rise_count <= stop_at + 1)
				else report_mismatch($sformatf("move %0d ran on after the stop", p));
		end
		assert (rise_count == 32'(pat_mem[b+9]))
			else report_mismatch($sformatf("move %0d gave %0d pulses, expected %0d",
				p, rise_count, pat_mem[b+9]));
		assert (first_rise_delay == exp_delay)
			else report_mismatch($sformatf("move %0d first pulse after %0d ticks, expected %0d",
				p, first_rise_delay, exp_delay));
		assert (tpsign == pat_mem[b+10][0])
			else report_mismatch($sformatf("move %0d tpsign %0b", p, tpsign));
		assert (axis_dir == cmd_dir && axis_ms == cmd_ms)
			else report_mismatch($sformatf("move %0d dir %0b ms %0d", p, axis_dir, axis_ms));
	endtask

	initial begin
		void'($urandom(32'hd2f2_59d7));
		resetn      = 1'b0;
		tick        = 1'b0;
		start       = 1'b0;
		stop        = 1'b0;
		cmd_dir     = 1'b0;
		cmd_speed   = '0;
		cmd_steps   = '0;
		cmd_ms      = '0;
		acce_max    = '0;
		deac_max    = '0;
		zpd         = 1'b0;
		stroke      = '0;
		xen         = 1'b0;
		xrst        = 1'b0;
		cycle_count = 0;
		tick_count  = 0;
		start_tick  = 0;
		rise_count  = 0;
		fall_count  = 0;
		phase       = 0;
		drive_prev  = 1'b0;
		// dir register comes out of reset as forward
		last_dir    = 1'b0;
		$readmemh("testbench/stepper_patterns.txt", pat_mem);
		cycle_limit = 0;
		for (int p = 0; p < n_pat; p++) begin
			cycle_limit += (32'(pat_mem[p*n_field+1]) + reverse_delay + 4)
				* (32'(motor_pkg::ramp_start) + 1) * 2 * 8;
		end
		repeat (2) begin
			step_clock();
		end
		assert (!drive && !busy && !zpsign && !tpsign)
			else report_mismatch("outputs not low after reset");
		resetn = 1'b1;
		for (int p = 0; p < n_pat; p++) begin
			run_move(p);
		end
		$display("All checks passed");
		$finish;
	end

endmodule

// File: testbench/stepper_patterns.txt
// dir steps speed ms acce_max deac_max stop_after zpd_after stroke exp_pulses exp_tpsign
// all hex; stop_after and zpd_after count completed pulses, 0 means unused
0 0008 0003 2 4 3 0 0 03e8 0008 0
0 0006 000c 5 5 5 0 0 03e8 0006 0
1 0005 0002 1 3 2 0 0 03e8 0005 0
1 0014 0001 3 6 6 7 0 03e8 0007 0
1 001e 0002 4 4 4 0 2 03e8 0002 0
0 0028 0002 6 8 8 0 0 000a 000a 1
1 0004 0003 0 2 2 0 0 000a 0004 0
1 0009 0005 7 3 4 3 0 03e8 0003 0
0 000c 0004 2 5 5 0 0 03e8 000c 0
0 0001 0006 1 1 1 0 0 03e8 0001 0

// File: stepper_axis.f
verilog/motor_pkg.sv
verilog/ramp_table.sv
verilog/speed_profile.sv
verilog/step_pulse_gen.sv
verilog/position_tracker.sv
verilog/motor_ctrl.sv
verilog/stepper_axis.sv
testbench/stepper_axis_sva.sv
testbench/tb_stepper_axis.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the stepper_axis testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "cannot enter the project directory"
	exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
	-f stepper_axis.f --top-module tb_stepper_axis -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_stepper_axis 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "All checks passed" <<< "$sim_out"; then
	exit 0
else
	echo "simulation did not report success"
	exit 1
fi
